/* design/i2c_defines.svh */
// I2C standby target parameters

`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// Fixed 7-bit address answered in standby mode
`define I2C_TARGET_ADDR 7'h0C

// Width of TTI queue data and descriptor words
`define TTI_DATA_W 32

// Acquisition FIFO entries, power of two
`define ACQ_DEPTH 8

`endif

/* design/i2c_target_pkg.sv */
// I2C standby target types

package i2c_target_pkg;

  // Kind of entry in the acquisition FIFO
  typedef enum logic [1:0] {
    ACQ_START = 2'd0,
    ACQ_DATA  = 2'd1,
    ACQ_STOP  = 2'd2
  } acq_op_e;

  // Err is only meaningful on ACQ_STOP
  typedef struct packed {
    acq_op_e    op;
    logic       rnw;
    logic       err;
    logic [7:0] data;
  } acq_entry_t;

  // Response descriptor written after every STOP
  typedef struct packed {
    logic [5:0]  reserved;
    logic        err;
    logic        rnw;
    logic [6:0]  addr;
    logic        pad;
    logic [15:0] len;
  } resp_desc_t;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    ADDR      = 3'd1,
    ADDR_ACK  = 3'd2,
    RX_BYTE   = 3'd3,
    RX_ACK    = 3'd4,
    TX_BYTE   = 3'd5,
    TX_ACK    = 3'd6,
    WAIT_STOP = 3'd7
  } tgt_state_e;

endpackage

/* design/i2c_target_fsm.sv */
// I2C target bit engine

`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_target_fsm (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            scl_i,
  input  logic                            sda_i,
  output logic                            sda_o,
  input  logic [7:0]                      tx_byte_i,
  input  logic                            tx_byte_valid_i,
  output logic                            tx_byte_ready_o,
  output i2c_target_pkg::acq_entry_t      acq_wdata_o,
  output logic                            acq_wvalid_o,
  input  logic [$clog2(`ACQ_DEPTH):0]     acq_free_i
);

  localparam int unsigned FREE_W = $clog2(`ACQ_DEPTH) + 1;

  // Two sync flops plus one history flop per line
  logic [2:0] scl_sync;
  logic [2:0] sda_sync;
  logic scl_s;
  logic scl_d;
  logic sda_s;
  logic sda_d;
  logic scl_rise;
  logic scl_fall;
  logic start_det;
  logic stop_det;

  i2c_target_pkg::tgt_state_e state;
  logic [3:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic [7:0] tx_next;
  logic rnw_q;
  logic active_q;
  logic underrun_q;
  logic host_ack;
  logic room_ok;
  logic addr_match;
  logic load_tx;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync <= 3'b111;
      sda_sync <= 3'b111;
    end else begin
      scl_sync <= {scl_sync[1:0], scl_i};
      sda_sync <= {sda_sync[1:0], sda_i};
    end
  end

  assign scl_s = scl_sync[1];
  assign scl_d = scl_sync[2];
  assign sda_s = sda_sync[1];
  assign sda_d = sda_sync[2];

  assign scl_rise  = scl_s && !scl_d;
  assign scl_fall  = !scl_s && scl_d;
  // SDA moving while SCL stays high
  assign start_det = scl_s && scl_d && sda_d && !sda_s;
  assign stop_det  = scl_s && scl_d && !sda_d && sda_s;

  // Keep one slot spare for the closing ACQ_STOP
  assign room_ok    = acq_free_i >= FREE_W'(2);
  assign addr_match = rx_shift[7:1] == `I2C_TARGET_ADDR;

  // Byte request on entry to TX_BYTE
  assign load_tx = scl_fall &&
                   ((state == i2c_target_pkg::ADDR_ACK && rnw_q) ||
                    (state == i2c_target_pkg::TX_ACK && host_ack));
  assign tx_byte_ready_o = load_tx;
  assign tx_next = tx_byte_valid_i ? tx_byte_i : 8'hFF;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state        <= i2c_target_pkg::IDLE;
      sda_o        <= 1'b1;
      bit_cnt      <= 4'd0;
      rnw_q        <= 1'b0;
      active_q     <= 1'b0;
      underrun_q   <= 1'b0;
      host_ack     <= 1'b0;
      acq_wvalid_o <= 1'b0;
    end else begin
      acq_wvalid_o <= 1'b0;
      if (start_det || stop_det) begin
        // Close a matched transfer on STOP or repeated START
        if (active_q) begin
          acq_wvalid_o     <= 1'b1;
          acq_wdata_o.op   <= i2c_target_pkg::ACQ_STOP;
          acq_wdata_o.rnw  <= rnw_q;
          acq_wdata_o.err  <= underrun_q;
          acq_wdata_o.data <= 8'h00;
        end
        active_q <= 1'b0;
        sda_o    <= 1'b1;
        bit_cnt  <= 4'd0;
        state    <= start_det ? i2c_target_pkg::ADDR : i2c_target_pkg::IDLE;
      end else if (load_tx) begin
        tx_shift <= tx_next;
        sda_o    <= tx_next[7];
        bit_cnt  <= 4'd0;
        state    <= i2c_target_pkg::TX_BYTE;
        if (!tx_byte_valid_i) begin
          underrun_q <= 1'b1;
        end
      end else begin
        case (state)
          i2c_target_pkg::ADDR: begin
            if (scl_rise) begin
              rx_shift <= {rx_shift[6:0], sda_s};
              bit_cnt  <= bit_cnt + 4'd1;
            end else if (scl_fall && bit_cnt == 4'd8) begin
              if (addr_match && room_ok) begin
                sda_o            <= 1'b0;
                rnw_q            <= rx_shift[0];
                active_q         <= 1'b1;
                underrun_q       <= 1'b0;
                acq_wvalid_o     <= 1'b1;
                acq_wdata_o.op   <= i2c_target_pkg::ACQ_START;
                acq_wdata_o.rnw  <= rx_shift[0];
                acq_wdata_o.err  <= 1'b0;
                acq_wdata_o.data <= rx_shift;
                state            <= i2c_target_pkg::ADDR_ACK;
              end else begin
                state <= i2c_target_pkg::WAIT_STOP;
              end
            end
          end
          i2c_target_pkg::ADDR_ACK: begin
            // Read direction leaves through load_tx
            if (scl_fall) begin
              sda_o   <= 1'b1;
              bit_cnt <= 4'd0;
              state   <= i2c_target_pkg::RX_BYTE;
            end
          end
          i2c_target_pkg::RX_BYTE: begin
            if (scl_rise) begin
              rx_shift <= {rx_shift[6:0], sda_s};
              bit_cnt  <= bit_cnt + 4'd1;
            end else if (scl_fall && bit_cnt == 4'd8) begin
              if (room_ok) begin
                sda_o            <= 1'b0;
                acq_wvalid_o     <= 1'b1;
                acq_wdata_o.op   <= i2c_target_pkg::ACQ_DATA;
                acq_wdata_o.rnw  <= 1'b0;
                acq_wdata_o.err  <= 1'b0;
                acq_wdata_o.data <= rx_shift;
              end
              state <= i2c_target_pkg::RX_ACK;
            end
          end
          i2c_target_pkg::RX_ACK: begin
            if (scl_fall) begin
              sda_o   <= 1'b1;
              bit_cnt <= 4'd0;
              state   <= i2c_target_pkg::RX_BYTE;
            end
          end
          i2c_target_pkg::TX_BYTE: begin
            if (scl_rise) begin
              bit_cnt <= bit_cnt + 4'd1;
            end else if (scl_fall) begin
              if (bit_cnt == 4'd8) begin
                sda_o <= 1'b1;
                state <= i2c_target_pkg::TX_ACK;
              end else begin
                sda_o    <= tx_shift[6];
                tx_shift <= {tx_shift[6:0], 1'b0};
              end
            end
          end
          i2c_target_pkg::TX_ACK: begin
            if (scl_rise) begin
              host_ack <= !sda_s;
            end else if (scl_fall) begin
              // Host NACK ends the read
              state <= i2c_target_pkg::WAIT_STOP;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Room was checked against the FIFO count before every write
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acq_wvalid_o |-> acq_free_i != '0);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !sda_o |-> state inside {i2c_target_pkg::ADDR_ACK, i2c_target_pkg::RX_ACK,
                             i2c_target_pkg::TX_BYTE});

endmodule

/* design/acq_fifo.sv */
// Acquisition FIFO

`timescale 1ns/1ps
`include "i2c_defines.svh"

module acq_fifo (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  i2c_target_pkg::acq_entry_t      wdata_i,
  input  logic                            wvalid_i,
  output logic [$clog2(`ACQ_DEPTH):0]     free_o,
  output i2c_target_pkg::acq_entry_t      rdata_o,
  output logic                            rvalid_o,
  input  logic                            rready_i
);

  localparam int unsigned DEPTH = `ACQ_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  i2c_target_pkg::acq_entry_t mem [DEPTH];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;
  logic full;
  logic do_wr;
  logic do_rd;

  assign full     = count == CNT_W'(DEPTH);
  assign do_wr    = wvalid_i && !full;
  assign do_rd    = rvalid_o && rready_i;
  assign rvalid_o = count != '0;
  assign rdata_o  = mem[rptr];
  assign free_o   = CNT_W'(DEPTH) - count;

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wptr <= wptr + PTR_W'(1);
      end
      if (do_rd) begin
        rptr <= rptr + PTR_W'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) wvalid_i |-> !full);

endmodule

/* design/flow_standby_i2c.sv */
// Standby I2C flow adapter

`timescale 1ns/1ps
`include "i2c_defines.svh"

module flow_standby_i2c (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  i2c_target_pkg::acq_entry_t  acq_rdata_i,
  input  logic                        acq_rvalid_i,
  output logic                        acq_rready_o,
  output logic [7:0]                  tx_byte_o,
  output logic                        tx_byte_valid_o,
  input  logic                        tx_byte_ready_i,
  input  logic [`TTI_DATA_W-1:0]      tx_queue_rdata_i,
  input  logic                        tx_queue_rvalid_i,
  output logic                        tx_queue_rready_o,
  output logic [`TTI_DATA_W-1:0]      rx_queue_wdata_o,
  output logic                        rx_queue_wvalid_o,
  input  logic                        rx_queue_wready_i,
  output i2c_target_pkg::resp_desc_t  rx_desc_queue_wdata_o,
  output logic                        rx_desc_queue_wvalid_o,
  input  logic                        rx_desc_queue_wready_i
);

  logic data_free;
  logic desc_free;
  logic pop;
  logic rnw_q;
  logic [15:0] wr_cnt;
  logic [15:0] rd_cnt;

  // TX bytes go straight to the engine
  assign tx_byte_o         = tx_queue_rdata_i[7:0];
  assign tx_byte_valid_o   = tx_queue_rvalid_i;
  assign tx_queue_rready_o = tx_byte_ready_i;

  // Pop only when both output slots are empty or draining, which keeps order
  assign data_free    = !rx_queue_wvalid_o || rx_queue_wready_i;
  assign desc_free    = !rx_desc_queue_wvalid_o || rx_desc_queue_wready_i;
  assign acq_rready_o = data_free && desc_free;
  assign pop          = acq_rvalid_i && acq_rready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      rnw_q                  <= 1'b0;
      wr_cnt                 <= 16'd0;
      rd_cnt                 <= 16'd0;
    end else begin
      if (rx_queue_wready_i) begin
        rx_queue_wvalid_o <= 1'b0;
      end
      if (rx_desc_queue_wready_i) begin
        rx_desc_queue_wvalid_o <= 1'b0;
      end

      // Each engine request sends one byte, queued or filler
      if (tx_byte_ready_i) begin
        rd_cnt <= rd_cnt + 16'd1;
      end

      if (pop) begin
        case (acq_rdata_i.op)
          i2c_target_pkg::ACQ_START: begin
            wr_cnt <= 16'd0;
            rnw_q  <= acq_rdata_i.rnw;
          end
          i2c_target_pkg::ACQ_DATA: begin
            rx_queue_wvalid_o <= 1'b1;
            rx_queue_wdata_o  <= {{(`TTI_DATA_W-8){1'b0}}, acq_rdata_i.data};
            wr_cnt            <= wr_cnt + 16'd1;
          end
          i2c_target_pkg::ACQ_STOP: begin
            rx_desc_queue_wvalid_o         <= 1'b1;
            rx_desc_queue_wdata_o.reserved <= 6'd0;
            rx_desc_queue_wdata_o.err      <= acq_rdata_i.err;
            rx_desc_queue_wdata_o.rnw      <= rnw_q;
            rx_desc_queue_wdata_o.addr     <= `I2C_TARGET_ADDR;
            rx_desc_queue_wdata_o.pad      <= 1'b0;
            rx_desc_queue_wdata_o.len      <= rnw_q ? rd_cnt : wr_cnt;
            // Read count restarts, keeping a request from this cycle
            if (rnw_q) begin
              rd_cnt <= {15'd0, tx_byte_ready_i};
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_queue_wvalid_o && !rx_queue_wready_i |=>
      rx_queue_wvalid_o && $stable(rx_queue_wdata_o));

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_desc_queue_wvalid_o && !rx_desc_queue_wready_i |=>
      rx_desc_queue_wvalid_o && $stable(rx_desc_queue_wdata_o));

endmodule

/* design/controller_standby_i2c.sv */
// Standby I2C target top

`timescale 1ns/1ps
`include "i2c_defines.svh"

module controller_standby_i2c (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        scl_i,
  input  logic                        sda_i,
  output logic                        sda_o,
  input  logic [`TTI_DATA_W-1:0]      tx_queue_rdata_i,
  input  logic                        tx_queue_rvalid_i,
  output logic                        tx_queue_rready_o,
  output logic [`TTI_DATA_W-1:0]      rx_queue_wdata_o,
  output logic                        rx_queue_wvalid_o,
  input  logic                        rx_queue_wready_i,
  output i2c_target_pkg::resp_desc_t  rx_desc_queue_wdata_o,
  output logic                        rx_desc_queue_wvalid_o,
  input  logic                        rx_desc_queue_wready_i
);

  logic [7:0] tx_byte;
  logic tx_byte_valid;
  logic tx_byte_ready;

  i2c_target_pkg::acq_entry_t acq_wdata;
  logic acq_wvalid;
  logic [$clog2(`ACQ_DEPTH):0] acq_free;
  i2c_target_pkg::acq_entry_t acq_rdata;
  logic acq_rvalid;
  logic acq_rready;

  i2c_target_fsm i_i2c_target_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .sda_o           (sda_o),
    .tx_byte_i       (tx_byte),
    .tx_byte_valid_i (tx_byte_valid),
    .tx_byte_ready_o (tx_byte_ready),
    .acq_wdata_o     (acq_wdata),
    .acq_wvalid_o    (acq_wvalid),
    .acq_free_i      (acq_free)
  );

  acq_fifo i_acq_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wdata_i  (acq_wdata),
    .wvalid_i (acq_wvalid),
    .free_o   (acq_free),
    .rdata_o  (acq_rdata),
    .rvalid_o (acq_rvalid),
    .rready_i (acq_rready)
  );

  flow_standby_i2c i_flow_standby_i2c (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .acq_rdata_i            (acq_rdata),
    .acq_rvalid_i           (acq_rvalid),
    .acq_rready_o           (acq_rready),
    .tx_byte_o              (tx_byte),
    .tx_byte_valid_o        (tx_byte_valid),
    .tx_byte_ready_i        (tx_byte_ready),
    .tx_queue_rdata_i       (tx_queue_rdata_i),
    .tx_queue_rvalid_i      (tx_queue_rvalid_i),
    .tx_queue_rready_o      (tx_queue_rready_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wready_i (rx_desc_queue_wready_i)
  );

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for two cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* sim/tb_controller_standby_i2c.sv */
// Standby I2C target testbench

`timescale 1ns/1ps
`include "i2c_defines.svh"

module tb_controller_standby_i2c;

  logic clk;
  logic rst_n;
  logic scl;
  logic sda_host;
  logic sda_line;
  logic sda_o;
  logic [`TTI_DATA_W-1:0] tx_queue_rdata_i;
  logic tx_queue_rvalid_i;
  logic tx_queue_rready_o;
  logic [`TTI_DATA_W-1:0] rx_queue_wdata_o;
  logic rx_queue_wvalid_o;
  logic rx_queue_wready_i;
  i2c_target_pkg::resp_desc_t rx_desc_queue_wdata_o;
  logic rx_desc_queue_wvalid_o;
  logic rx_desc_queue_wready_i;

  int mismatch_cnt = 0;
  int fail_cnt = 0;
  logic [31:0] data_lfsr = 32'hb50e;
  logic [31:0] rdy_lfsr = 32'hb50e;
  logic bp_en = 1'b0;

  // TX queue model
  logic [7:0] tx_mem [16];
  int tx_wr_cnt = 0;
  int tx_rd_idx = 0;
  logic tx_take = 1'b0;
  // Queue bytes the host has already read back
  int tx_used = 0;

  // Scoreboard, each entry tagged with its transfer number
  logic [7:0] exp_data_q[$];
  int exp_data_id_q[$];
  logic [31:0] exp_desc_q[$];
  int exp_desc_id_q[$];
  int xfer_id = 0;
  int data_pushed = 0;
  int data_popped = 0;

  tb_clk_gen i_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  // Open-drain wired-AND
  assign sda_line = sda_host & sda_o;

  controller_standby_i2c i_controller_standby_i2c (
    .clk_i                  (clk),
    .rst_n_i                (rst_n),
    .scl_i                  (scl),
    .sda_i                  (sda_line),
    .sda_o                  (sda_o),
    .tx_queue_rdata_i       (tx_queue_rdata_i),
    .tx_queue_rvalid_i      (tx_queue_rvalid_i),
    .tx_queue_rready_o      (tx_queue_rready_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wready_i (rx_desc_queue_wready_i)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    scl                    = 1'b1;
    sda_host               = 1'b1;
    tx_queue_rdata_i       = '0;
    tx_queue_rvalid_i      = 1'b0;
    rx_queue_wready_i      = 1'b1;
    rx_desc_queue_wready_i = 1'b1;
  end

  // Queue models and output monitors
  always @(negedge clk) begin
    if (rst_n) begin
      if (tx_take) begin
        tx_rd_idx = tx_rd_idx + 1;
      end
      tx_queue_rvalid_i = tx_rd_idx < tx_wr_cnt;
      tx_queue_rdata_i  = {24'd0, tx_mem[tx_rd_idx % 16]};
      tx_take = tx_queue_rvalid_i && tx_queue_rready_o;

      rdy_lfsr = lfsr_next(rdy_lfsr);
      rx_queue_wready_i = bp_en ? rdy_lfsr[0] : 1'b1;
      rdy_lfsr = lfsr_next(rdy_lfsr);
      rx_desc_queue_wready_i = bp_en ? rdy_lfsr[0] : 1'b1;

      if (rx_queue_wvalid_o && rx_queue_wready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("RX data queue got a byte that no transfer wrote");
          fail_cnt++;
        end else begin
          assert (rx_queue_wdata_o == {24'd0, exp_data_q[0]}) else begin
            $display("MISMATCH rx_queue_wdata_o exp %h got %h", exp_data_q[0],
                     rx_queue_wdata_o);
            mismatch_cnt++;
          end
          void'(exp_data_q.pop_front());
          void'(exp_data_id_q.pop_front());
          data_popped++;
        end
      end

      if (rx_desc_queue_wvalid_o && rx_desc_queue_wready_i) begin
        if (exp_desc_q.size() == 0) begin
          $display("RX descriptor queue got a descriptor that no transfer produced");
          fail_cnt++;
        end else begin
          assert (rx_desc_queue_wdata_o == exp_desc_q[0]) else begin
            $display("MISMATCH rx_desc_queue_wdata_o exp %h got %h", exp_desc_q[0],
                     rx_desc_queue_wdata_o);
            mismatch_cnt++;
          end
          if (exp_data_id_q.size() > 0 && exp_data_id_q[0] <= exp_desc_id_q[0]) begin
            $display("Descriptor arrived before all data bytes of its transfer");
            fail_cnt++;
          end
          void'(exp_desc_q.pop_front());
          void'(exp_desc_id_q.pop_front());
        end
      end
    end
  end

  assert property (@(posedge clk) rx_queue_wvalid_o |-> rx_queue_wdata_o[31:8] == 24'd0)
    else begin
      $display("MISMATCH rx_queue_wdata_o upper bits got %h", rx_queue_wdata_o);
      mismatch_cnt++;
    end

  assert property (@(posedge clk) rst_n && !$past(rst_n) |->
                   sda_o && !tx_queue_rready_o && !rx_queue_wvalid_o &&
                   !rx_desc_queue_wvalid_o)
    else begin
      $display("DUT outputs were not idle after reset");
      fail_cnt++;
    end

  task automatic cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = 8'd0;
    for (int i = 0; i < 8; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      b = {b[6:0], data_lfsr[0]};
    end
    return b;
  endfunction

  task automatic bus_start();
    sda_host = 1'b1;
    scl = 1'b1;
    cycles(10);
    sda_host = 1'b0;
    cycles(10);
    scl = 1'b0;
    cycles(2);
  endtask

  task automatic bus_stop();
    sda_host = 1'b0;
    cycles(10);
    scl = 1'b1;
    cycles(10);
    sda_host = 1'b1;
    cycles(10);
  endtask

  // One SCL pulse, SDA sampled mid high phase
  task automatic bus_bit(input logic b, output logic r);
    sda_host = b;
    cycles(10);
    scl = 1'b1;
    cycles(5);
    r = sda_line;
    cycles(5);
    scl = 1'b0;
    cycles(2);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic ack);
    logic r;
    for (int i = 7; i >= 0; i--) begin
      bus_bit(b[i], r);
    end
    bus_bit(1'b1, r);
    ack = !r;
  endtask

  task automatic recv_byte(input logic ack, output logic [7:0] b);
    logic r;
    b = 8'd0;
    for (int i = 0; i < 8; i++) begin
      bus_bit(1'b1, r);
      b = {b[6:0], r};
    end
    bus_bit(!ack, r);
  endtask

  task automatic push_desc(input logic err, input logic rnw, input int len);
    i2c_target_pkg::resp_desc_t d;
    d = '0;
    d.err  = err;
    d.rnw  = rnw;
    d.addr = `I2C_TARGET_ADDR;
    d.len  = 16'(len);
    exp_desc_q.push_back(d);
    exp_desc_id_q.push_back(xfer_id);
  endtask

  // Strict mode demands the ACK pattern of a target with room to spare
  task automatic host_write(input logic [6:0] addr, input int n, input logic strict);
    logic ack;
    logic addr_ack;
    logic exp_ack;
    logic [7:0] b;
    int len;
    int idx;
    len = 0;
    xfer_id++;
    exp_ack = addr == `I2C_TARGET_ADDR;
    bus_start();
    send_byte({addr, 1'b0}, addr_ack);
    if (strict) begin
      assert (addr_ack == exp_ack) else begin
        $display("MISMATCH address ack exp %h got %h", exp_ack, addr_ack);
        mismatch_cnt++;
      end
    end
    if (addr_ack) begin
      for (int i = 0; i < n; i++) begin
        b = rand_byte();
        // The byte can reach the RX queue before its ACK bit ends
        idx = data_pushed;
        exp_data_q.push_back(b);
        exp_data_id_q.push_back(xfer_id);
        data_pushed++;
        send_byte(b, ack);
        if (strict) begin
          assert (ack) else begin
            $display("MISMATCH data ack exp 1 got %h", ack);
            mismatch_cnt++;
          end
        end
        if (ack) begin
          len++;
        end else if (data_popped > idx) begin
          $display("Target stored a data byte that it NACKed");
          fail_cnt++;
        end else begin
          void'(exp_data_q.pop_back());
          void'(exp_data_id_q.pop_back());
          data_pushed--;
        end
      end
      // The descriptor can leave right after the STOP
      push_desc(1'b0, 1'b0, len);
    end
    bus_stop();
  endtask

  // Bytes past the end of the TX queue come back as 0xFF
  task automatic host_read(input int n);
    logic ack;
    logic [7:0] b;
    logic [7:0] exp_b;
    logic err;
    int base;
    err = 1'b0;
    base = tx_used;
    xfer_id++;
    bus_start();
    send_byte({`I2C_TARGET_ADDR, 1'b1}, ack);
    assert (ack) else begin
      $display("MISMATCH read address ack exp 1 got %h", ack);
      mismatch_cnt++;
    end
    for (int i = 0; i < n; i++) begin
      recv_byte(i != n - 1, b);
      exp_b = (base + i < tx_wr_cnt) ? tx_mem[(base + i) % 16] : 8'hFF;
      if (base + i >= tx_wr_cnt) begin
        err = 1'b1;
      end
      assert (b == exp_b) else begin
        $display("MISMATCH sda read byte exp %h got %h", exp_b, b);
        mismatch_cnt++;
      end
    end
    tx_used = (base + n < tx_wr_cnt) ? base + n : tx_wr_cnt;
    assert (tx_rd_idx == tx_used) else begin
      $display("MISMATCH tx_queue_rready_o pops exp %h got %h", tx_used, tx_rd_idx);
      mismatch_cnt++;
    end
    push_desc(err, 1'b1, n);
    bus_stop();
  endtask

  task automatic wait_drain(input int limit);
    int cnt;
    cnt = 0;
    while ((exp_data_q.size() > 0 || exp_desc_q.size() > 0) && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= limit) begin
      $display("Timeout waiting for RX data and descriptors to drain");
      fail_cnt++;
    end
  endtask

  task automatic wait_reset(input int limit);
    int cnt;
    cnt = 0;
    while (!rst_n && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= limit) begin
      $display("Timeout waiting for reset release");
      fail_cnt++;
    end
  endtask

  initial begin
    wait_reset(50);
    cycles(20);

    host_write(`I2C_TARGET_ADDR, 4, 1'b1);
    wait_drain(2000);

    for (int i = 0; i < 3; i++) begin
      tx_mem[tx_wr_cnt % 16] = rand_byte();
      tx_wr_cnt++;
    end
    host_read(3);
    wait_drain(2000);

    host_write(7'h22, 1, 1'b1);
    cycles(300);

    host_read(1);
    wait_drain(2000);

    bp_en = 1'b1;
    host_write(`I2C_TARGET_ADDR, 6, 1'b0);
    host_write(`I2C_TARGET_ADDR, 2, 1'b0);
    wait_drain(4000);
    bp_en = 1'b0;
    cycles(20);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+design
design/i2c_target_pkg.sv
design/i2c_target_fsm.sv
design/acq_fifo.sv
design/flow_standby_i2c.sv
design/controller_standby_i2c.sv
sim/tb_clk_gen.sv
sim/tb_controller_standby_i2c.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_controller_standby_i2c
RTL_TOP   ?= controller_standby_i2c
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
